// ==== verification/dramGolden.txt ====
# op (W write, R read), CPU byte address in hex, data in hex
# write lines give the data stored, read lines the data expected back
W 00000000 1234
W 00000802 abcd
W 01000010 5a5a
W 02fff7fe c3c3
W 03fffffe ffff
R 00000000 1234
R 00000802 abcd
R 01000010 5a5a
R 02fff7fe c3c3
R 03fffffe ffff
W 00000000 0f0f
R 00000000 0f0f
W 01234566 8001
W 01234568 7ffe
R 01234566 8001
R 01234568 7ffe
W 02000400 0000
R 02000400 0000
W 03800002 beef
W 00400000 cafe
R 03800002 beef
R 00400000 cafe
W 0155aaaa 55aa
R 0155aaaa 55aa

// ==== vlog.f ====
common/dramPkg.sv
verilog/downTimer.sv
dramController/dramSequencer.sv
dramController/sdramPort.sv
dramController/m68kDramController.sv
verification/tbClock.sv
verification/tbChecker.sv
verification/tbM68kDram.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tbM68kDram -o simM68kDram

out=$(./obj_dir/simM68kDram)
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
else
    exit 1
fi

// ==== verification/tbM68kDram.sv ====
// tbM68kDram: testbench top with the controller, an SDRAM model and golden file bus stimulus
`default_nettype none

module tbM68kDram;

    logic        Clock, Reset_L;
    logic [31:0] Address;
    logic [15:0] DataIn, DataOut;
    logic        AS_L, DramSelect_L, WE_L, UDS_L, LDS_L;
    logic        Dtack_L, ResetOut_L;
    logic        SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L;
    logic [12:0] SDram_Addr;
    logic [1:0]  SDram_BA;
    wire  [15:0] SDram_DQ;
    logic [4:0]  pinCmd;

    logic        opIsRead;                         // info for the checker
    logic [15:0] expData;
    int          testIndex;
    int          errorCount, checkCount;

    logic        opWrite[$];                       // golden file contents
    logic [31:0] opAddr[$];
    logic [15:0] opData[$];
    logic        loaded;

    tbClock clk0 (.Clock, .Reset_L);

    m68kDramController dut0 (
        .Clock, .Reset_L, .Address, .DataIn, .AS_L, .DramSelect_L, .WE_L, .UDS_L, .LDS_L,
        .DataOut, .Dtack_L, .ResetOut_L,
        .SDram_CKE_H, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
        .SDram_Addr, .SDram_BA, .SDram_DQ
    );

    tbChecker chk0 (
        .Clock, .Reset_L, .Address, .AS_L, .UDS_L, .LDS_L, .Dtack_L, .ResetOut_L,
        .DataOut, .pinCmd, .SDram_Addr, .SDram_BA, .opIsRead, .expData, .testIndex,
        .errorCount, .checkCount
    );

    assign pinCmd = {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};

    //////////////////////////////////////////////////////////////////////
    // behavioral SDRAM, CAS latency 2, one word per access
    //////////////////////////////////////////////////////////////////////
    logic [15:0] mem [logic [24:0]];               // {bank, row, col}
    logic [12:0] openRow [4];
    logic        readPend, modelDrive;
    logic [15:0] readWord, modelWord;

    assign SDram_DQ = modelDrive ? modelWord : 'z;

    initial begin
        readPend   = 1'b0;
        modelDrive = 1'b0;
    end

    always @(posedge Clock) begin
        if (pinCmd == dramPkg::BankActivate) openRow[SDram_BA] <= SDram_Addr;
        if (pinCmd == dramPkg::WriteAuto) begin
            mem[{SDram_BA, openRow[SDram_BA], SDram_Addr[9:0]}] = SDram_DQ;
        end
        if (pinCmd == dramPkg::ReadAuto) begin
            if (mem.exists({SDram_BA, openRow[SDram_BA], SDram_Addr[9:0]})) begin
                readWord <= mem[{SDram_BA, openRow[SDram_BA], SDram_Addr[9:0]}];
            end else begin
                readWord <= 16'hdead;              // never written
            end
        end
        readPend   <= (pinCmd == dramPkg::ReadAuto);
        modelDrive <= readPend;                    // data two clocks after the command
        modelWord  <= readWord;
    end

    //////////////////////////////////////////////////////////////////////
    // 68000 bus stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic loadGolden();
        int    fd, n;
        string line;
        logic [7:0]  opChar;
        logic [31:0] a;
        logic [15:0] d;
        fd = $fopen("verification/dramGolden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verification/dramGolden.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", opChar, a, d);
                if (n == 3) begin
                    opWrite.push_back(opChar == "W");
                    opAddr.push_back(a);
                    opData.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic busCycle(input int idx);
        @(posedge Clock);
        #2;
        testIndex    = idx;
        opIsRead     = !opWrite[idx];
        expData      = opData[idx];
        Address      = opAddr[idx];
        WE_L         = !opWrite[idx];
        AS_L         = 1'b0;
        DramSelect_L = 1'b0;
        UDS_L        = 1'b0;                       // word access, both strobes
        LDS_L        = 1'b0;
        if (opWrite[idx]) begin
            DataIn = opData[idx];                  // write data with the strobes
        end
        while (Dtack_L) begin
            @(posedge Clock);
            #2;
        end
        repeat (2) @(posedge Clock);
        #2;
        AS_L         = 1'b1;                       // end of cycle, all together
        DramSelect_L = 1'b1;
        UDS_L        = 1'b1;
        LDS_L        = 1'b1;
        repeat ($urandom_range(20, 0)) @(posedge Clock);
    endtask

    initial begin
        Address      = '0;
        DataIn       = '0;
        AS_L         = 1'b1;
        DramSelect_L = 1'b1;
        WE_L         = 1'b1;
        UDS_L        = 1'b1;
        LDS_L        = 1'b1;
        opIsRead     = 1'b0;
        expData      = '0;
        testIndex    = 0;
        loaded       = 1'b0;
        void'($urandom(32'h2e177955));
        loadGolden();
        loaded = 1'b1;
        wait (ResetOut_L === 1'b1);
        for (int i = 0; i < opWrite.size(); i++) begin
            busCycle(i);
        end
        repeat (800) @(posedge Clock);             // idle stretch, refresh only
        $display("Checks: %0d, errors: %0d, operations: %0d",
                 checkCount, errorCount, opWrite.size());
        if (errorCount == 0 && opWrite.size() > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog scaled to the number of golden operations
    initial begin
        wait (loaded);
        repeat (1000 + opWrite.size() * 80) @(posedge Clock);
        $display("Timeout: the run did not finish in the allowed number of clocks");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tbChecker.sv ====
// tbChecker: watches the controller's bus and SDRAM pins and counts rule violations
`default_nettype none

module tbChecker (
    input  wire logic        Clock,
    input  wire logic        Reset_L,
    input  wire logic [31:0] Address,
    input  wire logic        AS_L,
    input  wire logic        UDS_L,
    input  wire logic        LDS_L,
    input  wire logic        Dtack_L,
    input  wire logic        ResetOut_L,
    input  wire logic [15:0] DataOut,
    input  wire logic [4:0]  pinCmd,
    input  wire logic [12:0] SDram_Addr,
    input  wire logic [1:0]  SDram_BA,
    input  wire logic        opIsRead,
    input  wire logic [15:0] expData,
    input  wire logic [31:0] testIndex,
    output int               errorCount,
    output int               checkCount
);

    logic dtackPrev, readArm;
    logic resetChecked, initChecked, sawPrecharge, modeOk, banksClosed;
    int   initRefreshes, refreshGap, releaseWait;
    int   readErrors, readChecks;                  // read data side, posedge
    int   pinErrors, pinChecks;                    // pin rules, negedge

    assign errorCount = readErrors + pinErrors;
    assign checkCount = readChecks + pinChecks;

    initial begin
        readErrors    = 0;
        readChecks    = 0;
        pinErrors     = 0;
        pinChecks     = 0;
        dtackPrev     = 1'b1;
        readArm       = 1'b0;
        resetChecked  = 1'b0;
        initChecked   = 1'b0;
        sawPrecharge  = 1'b0;
        modeOk        = 1'b0;
        banksClosed   = 1'b0;
        initRefreshes = 0;
        refreshGap    = 0;
        releaseWait   = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // read data, checked on the second rising edge after Dtack_L falls
    //////////////////////////////////////////////////////////////////////
    always @(posedge Clock) begin
        if (readArm) begin
            readChecks = readChecks + 1;
            if (DataOut !== expData) begin
                readErrors = readErrors + 1;
                $display("** Error: read #%0d data: expected %h, actual %h",
                         testIndex, expData, DataOut);
            end
        end
        readArm   <= Reset_L && dtackPrev && !Dtack_L && opIsRead;   // fall seen here
        dtackPrev <= Dtack_L;
    end

    //////////////////////////////////////////////////////////////////////
    // pin level rules, sampled mid-cycle where everything is settled
    //////////////////////////////////////////////////////////////////////
    always @(negedge Clock) begin
        if (!Reset_L && !resetChecked) begin
            resetChecked = 1'b1;
            pinChecks    = pinChecks + 1;
            if (pinCmd[4] || ResetOut_L || !Dtack_L) begin
                pinErrors = pinErrors + 1;
                $display("Reset state is wrong: CKE, ResetOut_L or Dtack_L not at reset value");
            end
        end
        if (Reset_L && !ResetOut_L) begin         // initialisation window
            if (pinCmd == dramPkg::PrechargeAll && SDram_Addr[10]) sawPrecharge = 1'b1;
            if (pinCmd == dramPkg::AutoRefresh && sawPrecharge) begin
                initRefreshes = initRefreshes + 1;
            end
            if (pinCmd == dramPkg::LoadModeReg && initRefreshes >= 8
                && SDram_Addr == 13'h220) modeOk = 1'b1;
        end
        if (ResetOut_L && !initChecked) begin
            initChecked = 1'b1;
            pinChecks   = pinChecks + 1;
            if (!sawPrecharge || !modeOk) begin
                pinErrors = pinErrors + 1;
                $display("Init sequence incomplete: %0d refreshes, precharge %0d, mode set %0d",
                         initRefreshes, sawPrecharge, modeOk);
            end
        end
        // refresh spacing and precharge before refresh
        if (pinCmd == dramPkg::PrechargeAll) banksClosed = 1'b1;
        if (pinCmd == dramPkg::BankActivate) banksClosed = 1'b0;
        if (pinCmd == dramPkg::AutoRefresh) begin
            pinChecks = pinChecks + 1;
            if (!banksClosed) begin
                pinErrors = pinErrors + 1;
                $display("AutoRefresh issued with no precharge-all since the last activate");
            end
            refreshGap = 0;
        end else if (ResetOut_L) begin
            refreshGap = refreshGap + 1;
            if (refreshGap == 375 + 40 + 1) begin  // report each late refresh once
                pinErrors = pinErrors + 1;
                $display("No AutoRefresh for more than %0d clocks", 375 + 40);
            end
        end
        // address mapping of the activate and column commands
        if (pinCmd == dramPkg::BankActivate) begin
            pinChecks = pinChecks + 1;
            if (AS_L) begin
                pinErrors = pinErrors + 1;
                $display("BankActivate issued while AS_L was high");
            end
            if (SDram_BA !== Address[25:24] || SDram_Addr !== Address[23:11]) begin
                pinErrors = pinErrors + 1;
                $display("** Error: access #%0d activate bank/row: expected %h/%h, actual %h/%h",
                         testIndex, Address[25:24], Address[23:11], SDram_BA, SDram_Addr);
            end
        end
        if (pinCmd == dramPkg::ReadAuto || pinCmd == dramPkg::WriteAuto) begin
            pinChecks = pinChecks + 1;
            if (SDram_BA !== Address[25:24] || SDram_Addr[9:0] !== Address[10:1]
                || SDram_Addr[10] !== 1'b1) begin
                pinErrors = pinErrors + 1;
                $display("** Error: access #%0d column: expected %h/1/%h, actual %h/%b/%h",
                         testIndex, Address[25:24], Address[10:1],
                         SDram_BA, SDram_Addr[10], SDram_Addr[9:0]);
            end
        end
        // Dtack_L release after the strobes go high
        if (AS_L && UDS_L && LDS_L && !Dtack_L) begin
            releaseWait = releaseWait + 1;
            if (releaseWait == 3) begin
                pinErrors = pinErrors + 1;
                $display("Dtack_L still low two clocks after access #%0d ended", testIndex);
            end
        end else begin
            releaseWait = 0;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
// tbClock: testbench clock of period 20 and an active low reset held for four cycles
`default_nettype none

module tbClock (
    output logic Clock,
    output logic Reset_L
);

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;                // period 20
    end

    initial begin
        Reset_L = 1'b0;
        repeat (4) @(posedge Clock);
        #2 Reset_L = 1'b1;                         // release just after the edge
    end

endmodule

`default_nettype wire

// ==== dramController/m68kDramController.sv ====
// m68kDramController: 68000 bus SDRAM controller top with sequencer, timers and pin stage
`default_nettype none

module m68kDramController (
    input  wire logic                             Clock,
    input  wire logic                             Reset_L,
    input  wire logic [dramPkg::AddrWidth-1:0]    Address,
    input  wire logic [dramPkg::DataWidth-1:0]    DataIn,
    input  wire logic                             AS_L,
    input  wire logic                             DramSelect_L,
    input  wire logic                             WE_L,
    input  wire logic                             UDS_L,
    input  wire logic                             LDS_L,
    output logic      [dramPkg::DataWidth-1:0]    DataOut,
    output logic                                  Dtack_L,
    output logic                                  ResetOut_L,
    output logic                                  SDram_CKE_H,
    output logic                                  SDram_CS_L,
    output logic                                  SDram_RAS_L,
    output logic                                  SDram_CAS_L,
    output logic                                  SDram_WE_L,
    output logic      [dramPkg::RowWidth-1:0]     SDram_Addr,
    output logic      [dramPkg::BankWidth-1:0]    SDram_BA,
    inout  wire       [dramPkg::DataWidth-1:0]    SDram_DQ
);

    //////////////////////////////////////////////////////////////////////
    // sequencer to timers and pin stage
    //////////////////////////////////////////////////////////////////////
    logic                              delayLoad, delayDone;
    logic [dramPkg::TimerWidth-1:0]    delayValue;
    logic                              refreshLoad, refreshDone;
    logic [dramPkg::TimerWidth-1:0]    refreshValue;
    dramPkg::DramCommand               nextCommand;
    logic [dramPkg::RowWidth-1:0]      nextAddr;
    logic [dramPkg::BankWidth-1:0]     nextBank;
    logic                              writeDrive, readLatch;
    logic [dramPkg::DataWidth-1:0]     writeData;
    logic                              dtackNext, cpuResetNext;

    dramSequencer seq0 (
        .Clock, .Reset_L, .Address, .DataIn, .AS_L, .DramSelect_L, .WE_L, .UDS_L, .LDS_L,
        .delayDone, .refreshDone,
        .delayLoad, .delayValue, .refreshLoad, .refreshValue,
        .nextCommand, .nextAddr, .nextBank, .writeDrive, .writeData, .readLatch,
        .dtackNext, .cpuResetNext
    );

    // short waits: power-up, tRP, tRFC, tRCD, CAS
    downTimer delayTimer (
        .Clock, .Reset_L,
        .load(delayLoad), .loadValue(delayValue),
        .count(), .done(delayDone)                 // only the zero flag is needed
    );

    // init refresh window, then the 375 clock refresh period
    downTimer refreshTimer (
        .Clock, .Reset_L,
        .load(refreshLoad), .loadValue(refreshValue),
        .count(), .done(refreshDone)
    );

    sdramPort port0 (
        .Clock, .Reset_L,
        .nextCommand, .nextAddr, .nextBank, .writeDrive, .writeData, .readLatch,
        .dtackNext, .cpuResetNext,
        .SDram_CKE_H, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
        .SDram_Addr, .SDram_BA, .Dtack_L, .ResetOut_L, .DataOut, .SDram_DQ
    );

endmodule

`default_nettype wire

// ==== dramController/sdramPort.sv ====
// sdramPort: pin stage that registers SDRAM commands and bus handshakes and captures read data
`default_nettype none

module sdramPort (
    input  wire logic                             Clock,
    input  wire logic                             Reset_L,
    input  wire dramPkg::DramCommand              nextCommand,
    input  wire logic [dramPkg::RowWidth-1:0]     nextAddr,
    input  wire logic [dramPkg::BankWidth-1:0]    nextBank,
    input  wire logic                             writeDrive,
    input  wire logic [dramPkg::DataWidth-1:0]    writeData,
    input  wire logic                             readLatch,
    input  wire logic                             dtackNext,
    input  wire logic                             cpuResetNext,
    output logic                                  SDram_CKE_H,
    output logic                                  SDram_CS_L,
    output logic                                  SDram_RAS_L,
    output logic                                  SDram_CAS_L,
    output logic                                  SDram_WE_L,
    output logic      [dramPkg::RowWidth-1:0]     SDram_Addr,
    output logic      [dramPkg::BankWidth-1:0]    SDram_BA,
    output logic                                  Dtack_L,
    output logic                                  ResetOut_L,
    output logic      [dramPkg::DataWidth-1:0]    DataOut,
    inout  wire       [dramPkg::DataWidth-1:0]    SDram_DQ
);

    dramPkg::DramCommand cmdQ;
    logic writeDriveQ;
    logic readLatchQ;
    logic [dramPkg::DataWidth-1:0] writeDataQ;

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            cmdQ        <= dramPkg::PoweringUp;    // CKE and CS low from reset
            Dtack_L     <= 1'b1;
            ResetOut_L  <= 1'b0;
            writeDriveQ <= 1'b0;
            readLatchQ  <= 1'b0;
        end else begin
            cmdQ        <= nextCommand;
            Dtack_L     <= dtackNext;
            ResetOut_L  <= cpuResetNext;
            writeDriveQ <= writeDrive;
            readLatchQ  <= readLatch;
        end
    end

    always_ff @(posedge Clock) begin
        SDram_Addr <= nextAddr;
        SDram_BA   <= nextBank;
        writeDataQ <= writeData;
    end

    assign {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} = cmdQ;

    // device owns DQ except during a write
    assign SDram_DQ = writeDriveQ ? writeDataQ : 'z;

    // mid-cycle capture, half a clock before the CL2 edge
    always_ff @(negedge Clock) begin
        if (readLatchQ) DataOut <= SDram_DQ;
    end

    // the device drives DQ after a read, so the controller stays off the bus
    assert property (@(posedge Clock) disable iff (!Reset_L)
        (cmdQ == dramPkg::ReadAuto) |-> !writeDriveQ [*3]);

endmodule

`default_nettype wire

// ==== dramController/dramSequencer.sv ====
// dramSequencer: FSM for SDRAM init, auto-refresh and single-word 68000 reads and writes
`default_nettype none

module dramSequencer (
    input  wire logic                             Clock,
    input  wire logic                             Reset_L,
    input  wire logic [dramPkg::AddrWidth-1:0]    Address,
    input  wire logic [dramPkg::DataWidth-1:0]    DataIn,
    input  wire logic                             AS_L,
    input  wire logic                             DramSelect_L,
    input  wire logic                             WE_L,
    input  wire logic                             UDS_L,
    input  wire logic                             LDS_L,
    input  wire logic                             delayDone,
    input  wire logic                             refreshDone,
    output logic                                  delayLoad,
    output logic      [dramPkg::TimerWidth-1:0]   delayValue,
    output logic                                  refreshLoad,
    output logic      [dramPkg::TimerWidth-1:0]   refreshValue,
    output dramPkg::DramCommand                   nextCommand,
    output logic      [dramPkg::RowWidth-1:0]     nextAddr,
    output logic      [dramPkg::BankWidth-1:0]    nextBank,
    output logic                                  writeDrive,
    output logic      [dramPkg::DataWidth-1:0]    writeData,
    output logic                                  readLatch,
    output logic                                  dtackNext,
    output logic                                  cpuResetNext
);

    dramPkg::SeqState state, stateNext;
    logic [dramPkg::RowWidth-1:0]  colAddr;        // column plus the auto-precharge bit
    logic [dramPkg::BankWidth-1:0] cpuBank;
    logic strobeLow;                               // either data strobe asserted
    logic busIdle;                                 // AS_L and both strobes released

    assign cpuBank   = Address[dramPkg::BankLsb +: dramPkg::BankWidth];
    assign strobeLow = !UDS_L || !LDS_L;
    assign busIdle   = AS_L && UDS_L && LDS_L;

    always_comb begin
        colAddr = '0;
        colAddr[dramPkg::ColWidth-1:0]    = Address[dramPkg::ColLsb +: dramPkg::ColWidth];
        colAddr[dramPkg::AutoPrechargeBit] = 1'b1;
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state <= dramPkg::PowerUpLoad;
        end else begin
            state <= stateNext;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and command decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        stateNext    = state;
        nextCommand  = dramPkg::Nop;
        nextAddr     = '0;
        nextBank     = '0;
        delayLoad    = 1'b0;
        delayValue   = '0;
        refreshLoad  = 1'b0;
        refreshValue = '0;
        writeDrive   = 1'b0;
        writeData    = DataIn;
        readLatch    = 1'b0;
        dtackNext    = 1'b1;
        cpuResetNext = 1'b1;
        // CPU stays in reset until the first pass through Idle
        if (state inside {dramPkg::PowerUpLoad, dramPkg::PowerUpWait, dramPkg::FirstNop,
                          dramPkg::PrechargeInit, dramPkg::InitRefresh, dramPkg::LoadMode,
                          dramPkg::PostModeNop}) begin
            cpuResetNext = 1'b0;
        end
        case (state)
            dramPkg::PowerUpLoad: begin
                nextCommand = dramPkg::PoweringUp;
                delayLoad   = 1'b1;
                delayValue  = dramPkg::PowerUpCycles;
                stateNext   = dramPkg::PowerUpWait;
            end
            dramPkg::PowerUpWait: begin
                nextCommand = dramPkg::PoweringUp; // CKE still low
                if (delayDone) stateNext = dramPkg::FirstNop;
            end
            dramPkg::FirstNop: stateNext = dramPkg::PrechargeInit;
            dramPkg::PrechargeInit: begin
                nextCommand  = dramPkg::PrechargeAll;
                nextAddr     = dramPkg::PrechargeAllAddr;
                refreshLoad  = 1'b1;               // bounds the init refresh burst
                refreshValue = dramPkg::InitRefreshCycles;
                delayLoad    = 1'b1;
                delayValue   = 16'd1;              // tRP before the first refresh
                stateNext    = dramPkg::InitRefresh;
            end
            dramPkg::InitRefresh: begin
                if (refreshDone) begin
                    stateNext = dramPkg::LoadMode;
                end else if (delayDone) begin
                    nextCommand = dramPkg::AutoRefresh;
                    delayLoad   = 1'b1;
                    delayValue  = dramPkg::RefreshGap;
                end
            end
            dramPkg::LoadMode: begin
                nextCommand = dramPkg::LoadModeReg;
                nextAddr    = dramPkg::ModeRegValue;
                delayLoad   = 1'b1;
                delayValue  = dramPkg::ModeNopCycles;
                stateNext   = dramPkg::PostModeNop;
            end
            dramPkg::PostModeNop, dramPkg::PostRefreshNop: begin
                if (delayDone) begin
                    refreshLoad  = 1'b1;           // arm the periodic refresh
                    refreshValue = dramPkg::RefreshInterval;
                    stateNext    = dramPkg::Idle;
                end
            end
            dramPkg::Idle: begin
                if (!AS_L && !DramSelect_L) begin  // an access beats a pending refresh
                    nextCommand = dramPkg::BankActivate;
                    nextAddr    = Address[dramPkg::RowLsb +: dramPkg::RowWidth];
                    nextBank    = cpuBank;
                    delayLoad   = 1'b1;
                    delayValue  = dramPkg::ActToReadCycles;
                    stateNext   = WE_L ? dramPkg::ReadDelay : dramPkg::WriteWaitStrobe;
                end else if (refreshDone) begin
                    nextCommand = dramPkg::PrechargeAll;
                    nextAddr    = dramPkg::PrechargeAllAddr;
                    stateNext   = dramPkg::RefreshNop;
                end
            end
            dramPkg::RefreshNop: stateNext = dramPkg::IssueRefresh;
            dramPkg::IssueRefresh: begin
                nextCommand = dramPkg::AutoRefresh;
                delayLoad   = 1'b1;
                delayValue  = dramPkg::RefreshGap; // tRFC
                stateNext   = dramPkg::PostRefreshNop;
            end
            dramPkg::ReadDelay: begin
                if (delayDone) stateNext = dramPkg::IssueRead;
            end
            dramPkg::IssueRead: begin
                nextCommand = dramPkg::ReadAuto;
                nextAddr    = colAddr;
                nextBank    = cpuBank;
                delayLoad   = 1'b1;
                delayValue  = dramPkg::CasCycles;
                stateNext   = dramPkg::ReadLatency;
            end
            dramPkg::ReadLatency: begin
                dtackNext = 1'b0;
                if (delayDone) begin
                    readLatch = 1'b1;              // lands on the falling edge in the CL2 window
                    stateNext = dramPkg::Terminate;
                end
            end
            dramPkg::WriteWaitStrobe: begin
                if (strobeLow && delayDone) begin  // CPU data valid and tRCD met
                    nextCommand = dramPkg::WriteAuto;
                    nextAddr    = colAddr;
                    nextBank    = cpuBank;
                    writeDrive  = 1'b1;
                    dtackNext   = 1'b0;
                    stateNext   = dramPkg::WriteHold;
                end
            end
            dramPkg::WriteHold: begin
                writeDrive = 1'b1;                 // hold DQ one more clock
                dtackNext  = 1'b0;
                stateNext  = dramPkg::Terminate;
            end
            dramPkg::Terminate: begin
                if (busIdle) begin
                    stateNext = dramPkg::Idle;
                end else begin
                    dtackNext = 1'b0;              // keep acking until the CPU lets go
                end
            end
            default: stateNext = dramPkg::PowerUpLoad;
        endcase
    end

    // only one direction per access
    assert property (@(posedge Clock) disable iff (!Reset_L)
        (readLatch || nextCommand == dramPkg::ReadAuto) |-> !writeDrive);

    // DQ is driven for the write command and the single hold clock behind it
    assert property (@(posedge Clock) disable iff (!Reset_L)
        writeDrive |-> (nextCommand == dramPkg::WriteAuto)
                       || (state == dramPkg::WriteHold
                           && $past(nextCommand) == dramPkg::WriteAuto));

endmodule

`default_nettype wire

// ==== verilog/downTimer.sv ====
// downTimer: loadable down-counter that parks at zero and flags it
`default_nettype none

module downTimer (
    input  wire logic                             Clock,
    input  wire logic                             Reset_L,
    input  wire logic                             load,
    input  wire logic [dramPkg::TimerWidth-1:0]   loadValue,
    output logic      [dramPkg::TimerWidth-1:0]   count,
    output logic                                  done
);

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            count <= '0;
        end else if (load) begin
            count <= loadValue;                    // load wins over counting
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign done = (count == '0);                   // stays high until the next load

    // parked at zero means parked, no wrap to all ones
    assert property (@(posedge Clock) disable iff (!Reset_L)
        (count == '0 && !load) |=> (count == '0));

endmodule

`default_nettype wire

// ==== common/dramPkg.sv ====
// dramPkg: command codes, sequencer states, widths and timing for the 68000 SDRAM controller
`default_nettype none

package dramPkg;

    //////////////////////////////////////////////////////////////////////
    // widths and CPU address map
    //////////////////////////////////////////////////////////////////////
    localparam int AddrWidth  = 32;                // 68000 address bus as seen by the controller
    localparam int DataWidth  = 16;
    localparam int RowWidth   = 13;                // also the width of the SDRAM address pins
    localparam int BankWidth  = 2;
    localparam int ColWidth   = 10;
    localparam int TimerWidth = 16;

    localparam int RowLsb  = 11;                   // row  = Address[23:11]
    localparam int BankLsb = 24;                   // bank = Address[25:24]
    localparam int ColLsb  = 1;                    // col  = Address[10:1], word addressed

    //////////////////////////////////////////////////////////////////////
    // device constants
    //////////////////////////////////////////////////////////////////////
    localparam logic [RowWidth-1:0] PrechargeAllAddr = 13'h400;   // A10 high selects all banks
    localparam logic [RowWidth-1:0] ModeRegValue     = 13'h220;   // CAS 2, burst length 1
    localparam int                  AutoPrechargeBit = 10;

    //////////////////////////////////////////////////////////////////////
    // timing, in clocks
    //////////////////////////////////////////////////////////////////////
    localparam logic [TimerWidth-1:0] PowerUpCycles     = 16'd8;    // short power-up wait
    localparam logic [TimerWidth-1:0] RefreshInterval   = 16'd375;  // 7.5 us at 50 MHz
    localparam logic [TimerWidth-1:0] InitRefreshCycles = 16'd41;   // room for 8+ refreshes
    localparam logic [TimerWidth-1:0] RefreshGap        = 16'd3;    // NOPs after each refresh
    localparam logic [TimerWidth-1:0] ModeNopCycles     = 16'd2;
    localparam logic [TimerWidth-1:0] ActToReadCycles   = 16'd2;    // tRCD, used for writes too
    localparam logic [TimerWidth-1:0] CasCycles         = 16'd1;

    // command bits are {CKE, CS_L, RAS_L, CAS_L, WE_L}
    typedef enum logic [4:0] {
        PoweringUp   = 5'b00000,                   // CKE and CS low while power settles
        Nop          = 5'b10111,
        PrechargeAll = 5'b10010,                   // needs A10 high
        AutoRefresh  = 5'b10001,
        LoadModeReg  = 5'b10000,
        BankActivate = 5'b10011,
        ReadAuto     = 5'b10101,                   // read, A10 high for auto-precharge
        WriteAuto    = 5'b10100                    // write, A10 high for auto-precharge
    } DramCommand;

    // 17 states, so the encoding needs 5 bits
    typedef enum logic [4:0] {
        PowerUpLoad, PowerUpWait,
        FirstNop, PrechargeInit, InitRefresh,
        LoadMode, PostModeNop,
        Idle,
        RefreshNop, IssueRefresh, PostRefreshNop,
        ReadDelay, IssueRead, ReadLatency,
        WriteWaitStrobe, WriteHold,
        Terminate
    } SeqState;

endpackage

`default_nettype wire
